/* hw/cpu_pkg.sv */
// cpu_pkg: word and register widths, memory op encoding, implemented csr addresses

package cpu_pkg;

  // fixed by rv32
  parameter int WORD_WD     = 32;
  parameter int GPR_ADDR_WD = 5;
  parameter int CSR_ADDR_WD = 12;

  // follows funct3 of load/store
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_op_e;

  // machine mode csrs, the only ones kept
  parameter logic [CSR_ADDR_WD-1:0] CSR_MSTATUS = 12'h300;
  parameter logic [CSR_ADDR_WD-1:0] CSR_MTVEC   = 12'h305;
  parameter logic [CSR_ADDR_WD-1:0] CSR_MEPC    = 12'h341;
  parameter logic [CSR_ADDR_WD-1:0] CSR_MCAUSE  = 12'h342;

endpackage

/* hw/es_ms_if.sv */
// es_ms_if: execute to memory stage bundle with producer and consumer modports

`timescale 1ns/10ps

interface es_ms_if;

  logic                                 valid;
  logic [cpu_pkg::GPR_ADDR_WD-1:0]      rd;
  logic [cpu_pkg::CSR_ADDR_WD-1:0]      csr;
  logic                                 gpr_wen;
  logic                                 csr_wen;
  logic                                 mem_ren;
  logic                                 mem_wen;
  cpu_pkg::mem_op_e                     mem_op;
  logic                                 csr_inst_sel;    // gpr takes csrrdata
  logic [cpu_pkg::WORD_WD-1:0]          rs2data;         // store data
  logic [cpu_pkg::WORD_WD-1:0]          csrrdata;        // old csr value
  logic [cpu_pkg::WORD_WD-1:0]          alu_result;      // also the mem address
  logic [cpu_pkg::WORD_WD-1:0]          csr_result;      // new csr value

  modport producer (
    output valid, rd, csr,
    output gpr_wen, csr_wen,
    output mem_ren, mem_wen, mem_op,
    output csr_inst_sel,
    output rs2data, csrrdata, alu_result, csr_result
  );

  modport consumer (
    input  valid, rd, csr,
    input  gpr_wen, csr_wen,
    input  mem_ren, mem_wen, mem_op,
    input  csr_inst_sel,
    input  rs2data, csrrdata, alu_result, csr_result
  );

endinterface

/* hw/ms_ws_if.sv */
// ms_ws_if: memory to write-back bundle with producer and consumer modports

`timescale 1ns/10ps

interface ms_ws_if;

  logic                                 valid;
  // gpr side
  logic                                 gpr_wen;
  logic [cpu_pkg::GPR_ADDR_WD-1:0]      rd;
  logic [cpu_pkg::WORD_WD-1:0]          gpr_data;
  // csr side
  logic                                 csr_wen;
  logic [cpu_pkg::CSR_ADDR_WD-1:0]      csr;
  logic [cpu_pkg::WORD_WD-1:0]          csr_data;

  modport producer (
    output valid,
    output gpr_wen, rd, gpr_data,
    output csr_wen, csr, csr_data
  );

  modport consumer (
    input  valid,
    input  gpr_wen, rd, gpr_data,
    input  csr_wen, csr, csr_data
  );

endinterface

/* hw/es_ms_reg.sv */
// es_ms_reg: execute/memory pipeline register with valid and qualified enables

`timescale 1ns/10ps

module es_ms_reg (
  input                                 i_clk,
  input                                 i_rst_n,
  input                                 i_valid,
  input  [cpu_pkg::GPR_ADDR_WD-1:0]     i_rd,
  input  [cpu_pkg::CSR_ADDR_WD-1:0]     i_csr,
  input                                 i_gpr_wen,
  input                                 i_csr_wen,
  input                                 i_mem_ren,
  input                                 i_mem_wen,
  input  cpu_pkg::mem_op_e              i_mem_op,
  input                                 i_csr_inst_sel,
  input  [cpu_pkg::WORD_WD-1:0]         i_rs2data,
  input  [cpu_pkg::WORD_WD-1:0]         i_csrrdata,
  input  [cpu_pkg::WORD_WD-1:0]         i_alu_result,
  input  [cpu_pkg::WORD_WD-1:0]         i_csr_result,
  es_ms_if.producer                     o_es_ms
);

  // control, bubbles never write
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_es_ms.valid   <= 1'b0;
      o_es_ms.gpr_wen <= 1'b0;
      o_es_ms.csr_wen <= 1'b0;
      o_es_ms.mem_ren <= 1'b0;
      o_es_ms.mem_wen <= 1'b0;
    end else begin
      o_es_ms.valid   <= i_valid;
      o_es_ms.gpr_wen <= i_valid & i_gpr_wen;
      o_es_ms.csr_wen <= i_valid & i_csr_wen;
      o_es_ms.mem_ren <= i_valid & i_mem_ren;
      o_es_ms.mem_wen <= i_valid & i_mem_wen;
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    o_es_ms.rd           <= i_rd;
    o_es_ms.csr          <= i_csr;
    o_es_ms.mem_op       <= i_mem_op;
    o_es_ms.csr_inst_sel <= i_csr_inst_sel;
    o_es_ms.rs2data      <= i_rs2data;
    o_es_ms.csrrdata     <= i_csrrdata;
    o_es_ms.alu_result   <= i_alu_result;
    o_es_ms.csr_result   <= i_csr_result;
  end

endmodule

/* hw/lsu.sv */
// lsu: data ram, byte-lane stores, load extension and gpr/csr result select

`timescale 1ns/10ps

module lsu #(
  parameter int MEM_DEPTH = 256
) (
  input                                 i_clk,
  input  [cpu_pkg::WORD_WD-1:0]         i_addr,
  input  [cpu_pkg::WORD_WD-1:0]         i_wdata,
  input  [cpu_pkg::WORD_WD-1:0]         i_alu_result,
  input  [cpu_pkg::WORD_WD-1:0]         i_csr_result,
  input  [cpu_pkg::WORD_WD-1:0]         i_csrrdata,
  input                                 i_mem_ren,
  input                                 i_mem_wen,
  input  cpu_pkg::mem_op_e              i_mem_op,
  input                                 i_csr_inst_sel,
  output logic [cpu_pkg::WORD_WD-1:0]   o_gpr_final_result,
  output logic [cpu_pkg::WORD_WD-1:0]   o_csr_final_result
);

  localparam int WD     = cpu_pkg::WORD_WD;
  localparam int NBYTE  = WD / 8;
  localparam int IDX_WD = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  logic [WD-1:0]                        mem [MEM_DEPTH];
  logic [IDX_WD-1:0]                    word_idx;
  logic [NBYTE-1:0]                     st_be;
  logic [WD-1:0]                        st_data;

  // access stage registers
  logic [WD-1:0]                        rdata_q;
  logic [1:0]                           off_q;
  cpu_pkg::mem_op_e                     op_q;
  logic                                 ren_q;
  logic                                 csr_inst_sel_q;
  logic [WD-1:0]                        alu_result_q;
  logic [WD-1:0]                        csrrdata_q;
  logic [WD-1:0]                        csr_result_q;

  logic [7:0]                           ld_byte;
  logic [15:0]                          ld_half;
  logic [WD-1:0]                        ld_data;

  assign word_idx = IDX_WD'(i_addr[WD-1:2] % MEM_DEPTH);

  // lanes from op and low address bits
  always_comb begin
    case (i_mem_op)
      cpu_pkg::MEM_B: begin
        st_be   = NBYTE'(1) << i_addr[1:0];
        st_data = {NBYTE{i_wdata[7:0]}};
      end
      cpu_pkg::MEM_H: begin
        st_be   = NBYTE'(3) << {i_addr[1], 1'b0};
        st_data = {(NBYTE/2){i_wdata[15:0]}};
      end
      cpu_pkg::MEM_W: begin
        st_be   = '1;
        st_data = i_wdata;
      end
      default: begin
        st_be   = '0; // unsigned ops have no store form
        st_data = i_wdata;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < NBYTE; i++) begin
      if (i_mem_wen && st_be[i]) begin
        mem[word_idx][8*i +: 8] <= st_data[8*i +: 8];
      end
    end
    if (i_mem_ren) begin
      rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge i_clk) begin
    off_q          <= i_addr[1:0];
    op_q           <= i_mem_op;
    ren_q          <= i_mem_ren;
    csr_inst_sel_q <= i_csr_inst_sel;
    alu_result_q   <= i_alu_result;
    csrrdata_q     <= i_csrrdata;
    csr_result_q   <= i_csr_result;
  end

  assign ld_byte = rdata_q[8*off_q +: 8];
  assign ld_half = off_q[1] ? rdata_q[31:16] : rdata_q[15:0];

  always_comb begin
    case (op_q)
      cpu_pkg::MEM_B:  ld_data = {{(WD-8){ld_byte[7]}}, ld_byte};
      cpu_pkg::MEM_BU: ld_data = {{(WD-8){1'b0}}, ld_byte};
      cpu_pkg::MEM_H:  ld_data = {{(WD-16){ld_half[15]}}, ld_half};
      cpu_pkg::MEM_HU: ld_data = {{(WD-16){1'b0}}, ld_half};
      default:         ld_data = rdata_q;
    endcase
  end

  always_comb begin
    if (ren_q) begin
      o_gpr_final_result = ld_data;
    end else if (csr_inst_sel_q) begin
      o_gpr_final_result = csrrdata_q; // csrrw and friends
    end else begin
      o_gpr_final_result = alu_result_q;
    end
  end

  assign o_csr_final_result = csr_result_q;

endmodule

/* hw/mem_stage.sv */
// mem_stage: lsu access and memory to write-back result registers

`timescale 1ns/10ps

module mem_stage #(
  parameter int MEM_DEPTH = 256
) (
  input                                 i_clk,
  input                                 i_rst_n,
  es_ms_if.consumer                     i_es_ms,
  ms_ws_if.producer                     o_ms_ws
);

  logic [cpu_pkg::WORD_WD-1:0]          lsu_addr;
  logic [cpu_pkg::WORD_WD-1:0]          ms_gpr_final_result;
  logic [cpu_pkg::WORD_WD-1:0]          ms_csr_final_result;

  assign lsu_addr = i_es_ms.alu_result; // rs1 + imm

  lsu #(
    .MEM_DEPTH            (MEM_DEPTH)
  ) u_lsu (
    .i_clk                (i_clk),
    .i_addr               (lsu_addr),
    .i_wdata              (i_es_ms.rs2data),
    .i_alu_result         (i_es_ms.alu_result),
    .i_csr_result         (i_es_ms.csr_result),
    .i_csrrdata           (i_es_ms.csrrdata),
    .i_mem_ren            (i_es_ms.mem_ren),
    .i_mem_wen            (i_es_ms.mem_wen),
    .i_mem_op             (i_es_ms.mem_op),
    .i_csr_inst_sel       (i_es_ms.csr_inst_sel),
    .o_gpr_final_result   (ms_gpr_final_result),
    .o_csr_final_result   (ms_csr_final_result)
  );

  // valid and enables, lined up with the ram read
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ms_ws.valid   <= 1'b0;
      o_ms_ws.gpr_wen <= 1'b0;
      o_ms_ws.csr_wen <= 1'b0;
    end else begin
      o_ms_ws.valid   <= i_es_ms.valid;
      o_ms_ws.gpr_wen <= i_es_ms.gpr_wen;
      o_ms_ws.csr_wen <= i_es_ms.csr_wen;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ms_ws.rd  <= i_es_ms.rd;
    o_ms_ws.csr <= i_es_ms.csr;
  end

  // already one cycle late out of the lsu
  assign o_ms_ws.gpr_data = ms_gpr_final_result;
  assign o_ms_ws.csr_data = ms_csr_final_result;

endmodule

/* hw/wb_regfile.sv */
// wb_regfile: gpr file, m-mode csr file, write-back commit and retire pulse

`timescale 1ns/10ps

module wb_regfile (
  input                                   i_clk,
  input                                   i_rst_n,
  ms_ws_if.consumer                       i_ms_ws,
  input  [cpu_pkg::GPR_ADDR_WD-1:0]       i_rs_addr,
  input  [cpu_pkg::CSR_ADDR_WD-1:0]       i_csr_raddr,
  output logic [cpu_pkg::WORD_WD-1:0]     o_rs_data,
  output logic [cpu_pkg::WORD_WD-1:0]     o_csr_rdata,
  output logic                            o_retire,
  output logic [cpu_pkg::GPR_ADDR_WD-1:0] o_rd,
  output logic [cpu_pkg::WORD_WD-1:0]     o_gpr_data
);

  localparam int NGPR = 2 ** cpu_pkg::GPR_ADDR_WD;

  logic [cpu_pkg::WORD_WD-1:0]            gpr [NGPR];
  logic [cpu_pkg::WORD_WD-1:0]            mstatus;
  logic [cpu_pkg::WORD_WD-1:0]            mtvec;
  logic [cpu_pkg::WORD_WD-1:0]            mepc;
  logic [cpu_pkg::WORD_WD-1:0]            mcause;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NGPR; i++) begin
        gpr[i] <= '0;
      end
    end else if (i_ms_ws.valid && i_ms_ws.gpr_wen && (i_ms_ws.rd != '0)) begin
      gpr[i_ms_ws.rd] <= i_ms_ws.gpr_data; // x0 never written
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_ms_ws.valid && i_ms_ws.csr_wen) begin
      case (i_ms_ws.csr)
        cpu_pkg::CSR_MSTATUS: mstatus <= i_ms_ws.csr_data;
        cpu_pkg::CSR_MTVEC:   mtvec   <= i_ms_ws.csr_data;
        cpu_pkg::CSR_MEPC:    mepc    <= i_ms_ws.csr_data;
        cpu_pkg::CSR_MCAUSE:  mcause  <= i_ms_ws.csr_data;
        default: ;            // unimplemented, dropped
      endcase
    end
  end

  assign o_rs_data = gpr[i_rs_addr];

  always_comb begin
    case (i_csr_raddr)
      cpu_pkg::CSR_MSTATUS: o_csr_rdata = mstatus;
      cpu_pkg::CSR_MTVEC:   o_csr_rdata = mtvec;
      cpu_pkg::CSR_MEPC:    o_csr_rdata = mepc;
      cpu_pkg::CSR_MCAUSE:  o_csr_rdata = mcause;
      default:              o_csr_rdata = '0;
    endcase
  end

  // retire strobe, one per committed bundle
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_retire <= 1'b0;
    end else begin
      o_retire <= i_ms_ws.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rd       <= i_ms_ws.rd;
    o_gpr_data <= i_ms_ws.gpr_data;
  end

endmodule

/* hw/mem_wb_top.sv */
// mem_wb_top: es/ms register, memory stage and write-back register file

`timescale 1ns/10ps

module mem_wb_top #(
  parameter int MEM_DEPTH = 256
) (
  input                                   i_clk,
  input                                   i_rst_n,
  // execute result
  input                                   i_valid,
  input  [cpu_pkg::GPR_ADDR_WD-1:0]       i_rd,
  input  [cpu_pkg::CSR_ADDR_WD-1:0]       i_csr,
  input                                   i_gpr_wen,
  input                                   i_csr_wen,
  input                                   i_mem_ren,
  input                                   i_mem_wen,
  input  cpu_pkg::mem_op_e                i_mem_op,
  input                                   i_csr_inst_sel,
  input  [cpu_pkg::WORD_WD-1:0]           i_rs2data,
  input  [cpu_pkg::WORD_WD-1:0]           i_csrrdata,
  input  [cpu_pkg::WORD_WD-1:0]           i_alu_result,
  input  [cpu_pkg::WORD_WD-1:0]           i_csr_result,
  // read ports
  input  [cpu_pkg::GPR_ADDR_WD-1:0]       i_rs_addr,
  input  [cpu_pkg::CSR_ADDR_WD-1:0]       i_csr_raddr,
  output [cpu_pkg::WORD_WD-1:0]           o_rs_data,
  output [cpu_pkg::WORD_WD-1:0]           o_csr_rdata,
  // retire
  output                                  o_retire,
  output [cpu_pkg::GPR_ADDR_WD-1:0]       o_rd,
  output [cpu_pkg::WORD_WD-1:0]           o_gpr_data
);

  es_ms_if u_es_ms_if ();
  ms_ws_if u_ms_ws_if ();

  es_ms_reg u_es_ms_reg (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_valid        (i_valid),
    .i_rd           (i_rd),
    .i_csr          (i_csr),
    .i_gpr_wen      (i_gpr_wen),
    .i_csr_wen      (i_csr_wen),
    .i_mem_ren      (i_mem_ren),
    .i_mem_wen      (i_mem_wen),
    .i_mem_op       (i_mem_op),
    .i_csr_inst_sel (i_csr_inst_sel),
    .i_rs2data      (i_rs2data),
    .i_csrrdata     (i_csrrdata),
    .i_alu_result   (i_alu_result),
    .i_csr_result   (i_csr_result),
    .o_es_ms        (u_es_ms_if.producer)
  );

  mem_stage #(
    .MEM_DEPTH      (MEM_DEPTH)
  ) u_mem_stage (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_es_ms        (u_es_ms_if.consumer),
    .o_ms_ws        (u_ms_ws_if.producer)
  );

  wb_regfile u_wb_regfile (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_ms_ws        (u_ms_ws_if.consumer),
    .i_rs_addr      (i_rs_addr),
    .i_csr_raddr    (i_csr_raddr),
    .o_rs_data      (o_rs_data),
    .o_csr_rdata    (o_csr_rdata),
    .o_retire       (o_retire),
    .o_rd           (o_rd),
    .o_gpr_data     (o_gpr_data)
  );

endmodule

/* tb/tb_mem_wb_assert.sv */
// bound assertions for retire latency, exclusive memory enables and the x0 read port

`timescale 1ns/10ps

module tb_mem_wb_assert (
  input                               i_clk,
  input                               i_rst_n,
  input                               i_valid,
  input                               i_mem_ren,
  input                               i_mem_wen,
  input  [cpu_pkg::GPR_ADDR_WD-1:0]   i_rs_addr,
  input  [cpu_pkg::WORD_WD-1:0]       i_rs_data,
  input                               i_retire
);

  int fail_count = 0; // failed attempts over the run

  // three stage latency without stalls
  a_retire_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |-> ##3 i_retire)
    else begin
      fail_count++;
      $error("o_retire missing three cycles after i_valid");
    end

  a_no_spurious_retire: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_valid |-> ##3 !i_retire)
    else begin
      fail_count++;
      $error("o_retire without a valid instruction three cycles before");
    end

  a_mem_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_mem_ren && i_mem_wen))
    else begin
      fail_count++;
      $error("load and store enabled together");
    end

  a_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_rs_addr == '0) |-> (i_rs_data == '0))
    else begin
      fail_count++;
      $error("x0 reads nonzero");
    end

endmodule

bind mem_wb_top tb_mem_wb_assert u_tb_mem_wb_assert (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_valid    (i_valid),
  .i_mem_ren  (i_mem_ren),
  .i_mem_wen  (i_mem_wen),
  .i_rs_addr  (i_rs_addr),
  .i_rs_data  (o_rs_data),
  .i_retire   (o_retire)
);

/* tb/tb_mem_wb.sv */
// directed testbench for mem_wb_top with clock, reset, test tasks and compare tasks

`timescale 1ns/10ps

module tb_mem_wb;

  logic                               i_clk = 1'b0;
  logic                               i_rst_n;
  logic                               i_valid;
  logic [cpu_pkg::GPR_ADDR_WD-1:0]    i_rd;
  logic [cpu_pkg::CSR_ADDR_WD-1:0]    i_csr;
  logic                               i_gpr_wen;
  logic                               i_csr_wen;
  logic                               i_mem_ren;
  logic                               i_mem_wen;
  cpu_pkg::mem_op_e                   i_mem_op;
  logic                               i_csr_inst_sel;
  logic [cpu_pkg::WORD_WD-1:0]        i_rs2data;
  logic [cpu_pkg::WORD_WD-1:0]        i_csrrdata;
  logic [cpu_pkg::WORD_WD-1:0]        i_alu_result;
  logic [cpu_pkg::WORD_WD-1:0]        i_csr_result;
  logic [cpu_pkg::GPR_ADDR_WD-1:0]    i_rs_addr;
  logic [cpu_pkg::CSR_ADDR_WD-1:0]    i_csr_raddr;
  logic [cpu_pkg::WORD_WD-1:0]        o_rs_data;
  logic [cpu_pkg::WORD_WD-1:0]        o_csr_rdata;
  logic                               o_retire;
  logic [cpu_pkg::GPR_ADDR_WD-1:0]    o_rd;
  logic [cpu_pkg::WORD_WD-1:0]        o_gpr_data;

  integer seed;
  int     errors = 0;
  int     n_pass = 0;
  int     n_fail = 0;

  mem_wb_top #(.MEM_DEPTH(256)) mem_wb_top_i (.*);

  always #50 i_clk = ~i_clk; // 100 ns period

  task automatic check_word(input string name, input logic [cpu_pkg::WORD_WD-1:0] exp,
                            input logic [cpu_pkg::WORD_WD-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_rd(input string name, input logic [cpu_pkg::GPR_ADDR_WD-1:0] exp,
                          input logic [cpu_pkg::GPR_ADDR_WD-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected rd %0d, actual rd %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      $display("test %s: pass", name);
      n_pass++;
    end else begin
      $display("test %s: FAIL (%0d errors)", name, errors - err0);
      n_fail++;
    end
  endtask

  // bubble on every input without a clock wait
  task automatic clear_inputs();
    i_valid        <= 1'b0;
    i_rd           <= '0;
    i_csr          <= '0;
    i_gpr_wen      <= 1'b0;
    i_csr_wen      <= 1'b0;
    i_mem_ren      <= 1'b0;
    i_mem_wen      <= 1'b0;
    i_mem_op       <= cpu_pkg::MEM_W;
    i_csr_inst_sel <= 1'b0;
    i_rs2data      <= '0;
    i_csrrdata     <= '0;
    i_alu_result   <= '0;
    i_csr_result   <= '0;
    i_rs_addr      <= '0;
    i_csr_raddr    <= '0;
  endtask

  task automatic drive_idle();
    @(posedge i_clk);
    clear_inputs();
    i_rs_addr <= i_rd; // keep reading back the last destination
  endtask

  // one instruction for one cycle with csr fields cleared
  task automatic issue_inst(input logic [cpu_pkg::GPR_ADDR_WD-1:0] rd, input logic gpr_wen,
                            input logic ren, input logic wen, input cpu_pkg::mem_op_e op,
                            input logic [cpu_pkg::WORD_WD-1:0] alu,
                            input logic [cpu_pkg::WORD_WD-1:0] wdata);
    @(posedge i_clk);
    clear_inputs();
    i_valid      <= 1'b1;
    i_rd         <= rd;
    i_gpr_wen    <= gpr_wen;
    i_mem_ren    <= ren;
    i_mem_wen    <= wen;
    i_mem_op     <= op;
    i_alu_result <= alu;
    i_rs2data    <= wdata;
    i_rs_addr    <= rd;
  endtask

  task automatic wait_retire(input string name);
    int cnt;
    cnt = 0;
    @(negedge i_clk);
    while (!o_retire && cnt < 10) begin
      @(negedge i_clk);
      cnt++;
    end
    if (!o_retire) begin
      $display("%s: timed out waiting for o_retire", name);
      errors++;
    end
  endtask

  task automatic do_inst(input string name, input logic [cpu_pkg::GPR_ADDR_WD-1:0] rd,
                         input logic gpr_wen, input logic ren, input logic wen,
                         input cpu_pkg::mem_op_e op, input logic [cpu_pkg::WORD_WD-1:0] alu,
                         input logic [cpu_pkg::WORD_WD-1:0] wdata);
    issue_inst(rd, gpr_wen, ren, wen, op, alu, wdata);
    drive_idle();
    wait_retire(name);
  endtask

  task automatic test_alu_wb();
    logic [cpu_pkg::WORD_WD-1:0] val;
    int err0;
    err0 = errors;
    val  = $random(seed);
    do_inst("alu_wb", 5, 1, 0, 0, cpu_pkg::MEM_W, val, 0);
    check_rd("alu_wb", 5, o_rd);
    check_word("alu_wb", val, o_gpr_data);
    check_word("alu_wb", val, o_rs_data);
    report_test("alu_wb", err0);
  endtask

  task automatic test_store_load();
    logic [cpu_pkg::WORD_WD-1:0] val;
    int err0;
    err0 = errors;
    val  = $random(seed);
    do_inst("store_load", 0, 0, 0, 1, cpu_pkg::MEM_W, 32'h20, val);
    do_inst("store_load", 6, 1, 1, 0, cpu_pkg::MEM_W, 32'h20, 0);
    check_rd("store_load", 6, o_rd);
    check_word("store_load", val, o_gpr_data);
    check_word("store_load", val, o_rs_data);
    report_test("store_load", err0);
  endtask

  task automatic test_subword();
    logic [7:0]                  bytes [4];
    logic [15:0]                 halves [2];
    logic [cpu_pkg::WORD_WD-1:0] val;
    int k;
    int err0;
    err0 = errors;
    for (k = 0; k < 4; k++) begin
      val      = $random(seed); // upper bits must be ignored
      val[7]   = k[0];          // both signs across the lanes
      bytes[k] = val[7:0];
      do_inst("subword", 0, 0, 0, 1, cpu_pkg::MEM_B, 32'h40 + k, val);
    end
    do_inst("subword", 7, 1, 1, 0, cpu_pkg::MEM_W, 32'h40, 0);
    check_word("subword lanes", {bytes[3], bytes[2], bytes[1], bytes[0]}, o_gpr_data);
    for (k = 0; k < 4; k++) begin
      do_inst("subword", 7, 1, 1, 0, cpu_pkg::MEM_B, 32'h40 + k, 0);
      check_word("subword load_b", {{24{bytes[k][7]}}, bytes[k]}, o_gpr_data);
      do_inst("subword", 7, 1, 1, 0, cpu_pkg::MEM_BU, 32'h40 + k, 0);
      check_word("subword load_bu", {24'h0, bytes[k]}, o_gpr_data);
    end
    for (k = 0; k < 2; k++) begin
      val       = $random(seed);
      val[15]   = (k == 0);
      halves[k] = val[15:0];
      do_inst("subword", 0, 0, 0, 1, cpu_pkg::MEM_H, 32'h44 + 2 * k, val);
    end
    for (k = 0; k < 2; k++) begin
      do_inst("subword", 9, 1, 1, 0, cpu_pkg::MEM_H, 32'h44 + 2 * k, 0);
      check_word("subword load_h", {{16{halves[k][15]}}, halves[k]}, o_gpr_data);
      do_inst("subword", 9, 1, 1, 0, cpu_pkg::MEM_HU, 32'h44 + 2 * k, 0);
      check_word("subword load_hu", {16'h0, halves[k]}, o_gpr_data);
    end
    report_test("subword", err0);
  endtask

  task automatic test_csr();
    logic [cpu_pkg::WORD_WD-1:0] old_val;
    logic [cpu_pkg::WORD_WD-1:0] new_val;
    int err0;
    err0    = errors;
    old_val = $random(seed);
    new_val = $random(seed);
    issue_inst(8, 1, 0, 0, cpu_pkg::MEM_W, 32'h0, 0);
    i_csr          <= cpu_pkg::CSR_MEPC;
    i_csr_wen      <= 1'b1;
    i_csr_inst_sel <= 1'b1;
    i_csrrdata     <= old_val;
    i_csr_result   <= new_val;
    drive_idle();
    i_csr_raddr <= cpu_pkg::CSR_MEPC;
    wait_retire("csr");
    check_rd("csr", 8, o_rd);
    check_word("csr gpr", old_val, o_gpr_data);
    check_word("csr gpr", old_val, o_rs_data);
    check_word("csr mepc", new_val, o_csr_rdata);
    report_test("csr", err0);
  endtask

  task automatic test_ignored_writes();
    int err0;
    err0 = errors;
    do_inst("ignored", 0, 1, 0, 0, cpu_pkg::MEM_W, $random(seed), 0);
    check_word("ignored x0", 32'h0, o_rs_data);
    issue_inst(0, 0, 0, 0, cpu_pkg::MEM_W, 32'h0, 0);
    i_csr        <= 12'h7c0;  // unimplemented custom csr
    i_csr_wen    <= 1'b1;
    i_csr_result <= $random(seed);
    drive_idle();
    i_csr_raddr <= 12'h7c0;
    wait_retire("ignored");
    check_word("ignored csr", 32'h0, o_csr_rdata);
    report_test("ignored", err0);
  endtask

  task automatic test_stream();
    logic [cpu_pkg::WORD_WD-1:0]     mem_model [8];
    logic [cpu_pkg::WORD_WD-1:0]     exp_data [8];
    logic [cpu_pkg::GPR_ADDR_WD-1:0] exp_rd [8];
    logic [cpu_pkg::WORD_WD-1:0]     val;
    int i;
    int err0;
    err0 = errors;
    for (i = 0; i < 8; i++) begin
      mem_model[i] = $random(seed);
      issue_inst(0, 0, 0, 1, cpu_pkg::MEM_W, 32'h100 + 4 * i, mem_model[i]);
    end
    for (i = 0; i < 11; i++) begin
      if (i < 8) begin
        exp_rd[i] = i[4:0] + 5'd1;
        val       = $random(seed);
        if (val[0]) begin
          exp_data[i] = mem_model[val[3:1]];
          issue_inst(exp_rd[i], 1, 1, 0, cpu_pkg::MEM_W, 32'h100 + 4 * val[3:1], 0);
        end else begin
          exp_data[i] = val;
          issue_inst(exp_rd[i], 1, 0, 0, cpu_pkg::MEM_W, val, 0);
        end
      end else begin
        drive_idle();
      end
      @(negedge i_clk);
      if (i >= 3) begin
        if (o_retire !== 1'b1) begin
          $display("stream: instruction %0d did not retire three cycles after issue", i - 3);
          errors++;
        end
        check_rd("stream", exp_rd[i-3], o_rd);
        check_word("stream", exp_data[i-3], o_gpr_data);
      end
    end
    report_test("stream", err0);
  endtask

  initial begin
    seed = 32'h6b884122;
    i_rst_n <= 1'b0;
    clear_inputs();
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;
    test_alu_wb();
    test_store_load();
    test_subword();
    test_csr();
    test_ignored_writes();
    test_stream();
    if (mem_wb_top_i.u_tb_mem_wb_assert.fail_count != 0) begin
      $display("bound assertions failed %0d times",
               mem_wb_top_i.u_tb_mem_wb_assert.fail_count);
      errors++;
    end
    $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (errors == 0 && n_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tb.f */
hw/cpu_pkg.sv
hw/es_ms_if.sv
hw/ms_ws_if.sv
hw/es_ms_reg.sv
hw/lsu.sv
hw/mem_stage.sv
hw/wb_regfile.sv
hw/mem_wb_top.sv
tb/tb_mem_wb_assert.sv
tb/tb_mem_wb.sv
